// ==== compile.f ====
+incdir+.
ucode_pkg.sv
ucode_seq_ctrl.sv
ucode_rom.sv
ucode_uop_build.sv
ucode_stage.sv
tb_clk_gen.sv
tb_ucode_checker.sv
tb_ucode_stage.sv

// ==== Bender.yml ====
package:
  name: ucode_stage

export_include_dirs:
  - .

sources:
  - ucode_pkg.sv
  - ucode_seq_ctrl.sv
  - ucode_rom.sv
  - ucode_uop_build.sv
  - ucode_stage.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - tb_ucode_checker.sv
      - tb_ucode_stage.sv

// ==== tb_ucode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ucode_stage;
   import ucode_pkg::*;

   localparam int EIP_W        = 32;
   localparam int RESET_CYCLES = 8;
   localparam int NUM_ORDERED  = 8;
   localparam int NUM_RANDOM   = 40;
   localparam int NUM_REQ      = NUM_ORDERED + NUM_RANDOM;
   localparam int CYCLE_LIMIT  = NUM_REQ * 40 + RESET_CYCLES;

   logic             clk;
   logic             rst_n;
   logic             dec_valid;
   logic             dec_ready;
   dec_req_t         dec_req;
   logic [EIP_W-1:0] eip;
   logic [EIP_W-1:0] eflags;
   uop_t             uop;
   logic             uop_valid;
   logic             uop_ready;
   logic             int_done;
   logic             random_ready;
   logic             run_end;
   int               tests_done;
   int               error_count;
   int               cycle_count;
   logic [31:0]      lfsr_q;

   logic [2:0]       req_prog     [NUM_REQ];
   logic [IMM_W-1:0] req_imm      [NUM_REQ];
   logic [EIP_W-1:0] req_eip      [NUM_REQ];
   logic [EIP_W-1:0] req_eflags   [NUM_REQ];
   logic             req_new_regs [NUM_REQ];

   tb_clk_gen #(
      .PERIOD       (100),
      .RESET_CYCLES (RESET_CYCLES)
   ) clk_gen_inst (
      .clk   (clk),
      .rst_n (rst_n)
   );

   ucode_stage #(
      .EIP_W (EIP_W)
   ) ucode_stage_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .dec_valid (dec_valid),
      .dec_ready (dec_ready),
      .dec_req   (dec_req),
      .eip       (eip),
      .eflags    (eflags),
      .uop       (uop),
      .uop_valid (uop_valid),
      .uop_ready (uop_ready),
      .int_done  (int_done)
   );

   tb_ucode_checker #(
      .EIP_W (EIP_W)
   ) checker_inst (
      .clk         (clk),
      .rst_n       (rst_n),
      .dec_valid   (dec_valid),
      .dec_ready   (dec_ready),
      .dec_req     (dec_req),
      .eip         (eip),
      .eflags      (eflags),
      .uop         (uop),
      .uop_valid   (uop_valid),
      .uop_ready   (uop_ready),
      .int_done    (int_done),
      .run_end     (run_end),
      .tests_done  (tests_done),
      .error_count (error_count)
   );

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};
   endfunction

   function automatic logic [63:0] rand_bits(input int n);
      logic [63:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_next(lfsr_q);
         r = {r[62:0], lfsr_q[0]};
      end
      return r;
   endfunction

   // All request data drawn at time zero, before the ready driver starts
   task automatic build_stimulus();
      for (int i = 0; i < NUM_REQ; i++) begin
         if (i < NUM_ORDERED) begin
            req_prog[i] = 3'(i);
         end else begin
            req_prog[i] = 3'(rand_bits(3));
         end
         req_imm[i]      = IMM_W'(rand_bits(IMM_W));
         req_eip[i]      = EIP_W'(rand_bits(EIP_W));
         req_eflags[i]   = EIP_W'(rand_bits(EIP_W));
         req_new_regs[i] = (i == 0) || (rand_bits(1) != 0);
      end
   endtask

   task automatic send_request(input int idx);
      dec_req_t req;
      req.prog    = ucode_prog_e'(req_prog[idx]);
      req.dec_imm = req_imm[idx];
      if (req_new_regs[idx]) begin
         // eip and eflags move only while the stage is idle
         @(posedge clk);
         while (!dec_ready) @(posedge clk);
         eip    <= req_eip[idx];
         eflags <= req_eflags[idx];
      end
      @(posedge clk);
      dec_valid <= 1'b1;
      dec_req   <= req;
      @(posedge clk);
      while (!dec_ready) @(posedge clk);
      dec_valid <= 1'b0;
   endtask

   always @(posedge clk) begin
      if (random_ready) begin
         // About three cycles in four ready
         uop_ready <= |rand_bits(2);
      end else begin
         uop_ready <= 1'b1;
      end
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= CYCLE_LIMIT) begin
         $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("Simulation failed");
         $finish;
      end
   end

   initial begin
      dec_valid    = 1'b0;
      dec_req      = '0;
      eip          = '0;
      eflags       = '0;
      uop_ready    = 1'b0;
      random_ready = 1'b0;
      run_end      = 1'b0;
      cycle_count  = 0;
      lfsr_q       = 32'd65971;
      build_stimulus();
      wait (rst_n === 1'b1);
      @(posedge clk);
      for (int i = 0; i < NUM_REQ; i++) begin
         // Ordered pass with uop_ready high, then random back-pressure
         if (i == NUM_ORDERED) begin
            random_ready <= 1'b1;
         end
         send_request(i);
      end
      while (tests_done != NUM_REQ) @(posedge clk);
      repeat (3) @(posedge clk);
      run_end = 1'b1;
      #1;
      if (error_count == 0 && tests_done == NUM_REQ) begin
         $display("Simulation completed successfully");
      end else begin
         $display("Simulation failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== tb_ucode_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_ucode_checker #(
   parameter int EIP_W = 32
) (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  dec_valid,
   input  logic                  dec_ready,
   input  ucode_pkg::dec_req_t   dec_req,
   input  logic [EIP_W-1:0]      eip,
   input  logic [EIP_W-1:0]      eflags,
   input  ucode_pkg::uop_t       uop,
   input  logic                  uop_valid,
   input  logic                  uop_ready,
   input  logic                  int_done,
   input  logic                  run_end,
   output int                    tests_done,
   output int                    error_count
);
   import ucode_pkg::*;

   `include "ucode_image.svh"

   uop_t exp_q[$];
   uop_t exp_uop;
   uop_t prev_uop;
   logic prev_stall;
   logic busy_m;
   logic full_m;
   logic take_m;
   logic accept;
   logic exp_int;
   logic reset_reported;
   int   left_m;
   int   cur_err;
   int   step_idx;
   int   tests_passed;
   int   tests_failed;
   int   uops_checked;

   initial begin
      tests_done     = 0;
      error_count    = 0;
      tests_passed   = 0;
      tests_failed   = 0;
      uops_checked   = 0;
      cur_err        = 0;
      step_idx       = 0;
      reset_reported = 1'b0;
   end

   function automatic logic [IMM_W-1:0] zero_ext(input logic [EIP_W-1:0] v);
      logic [IMM_W-1:0] r;
      r = '0;
      r[EIP_W-1:0] = v;
      return r;
   endfunction

   // Expected micro-operations of one request, straight from the image
   task automatic expand_request(input dec_req_t req, input logic [EIP_W-1:0] e,
                                 input logic [EIP_W-1:0] f);
      rom_word_t w;
      uop_t      u;
      int        base;
      int        n;
      base = PROG_OFFSET[req.prog];
      n    = PROG_LAST[req.prog];
      for (int k = 0; k <= n; k++) begin
         w = UCODE_IMAGE[base + k];
         u.size               = w.size;
         u.set_d              = w.set_d;
         u.clr_d              = w.clr_d;
         u.op0                = w.op0;
         u.op1                = w.op1;
         u.op0_reg            = w.op0_reg;
         u.op1_reg            = w.op1_reg;
         u.modrm              = w.modrm;
         u.sib                = w.sib;
         u.alu_op             = w.alu_op;
         u.flag0              = w.flag0;
         u.flag1              = w.flag1;
         u.stack_op           = w.stack_op;
         u.seg_override       = w.seg_override;
         u.seg_override_valid = w.seg_override_valid;
         if (w.imm_sel == IMM_DEC) begin
            u.imm = req.dec_imm;
         end else if (w.imm_sel == IMM_EIP) begin
            u.imm = zero_ext(e);
         end else if (w.imm_sel == IMM_EFLAGS) begin
            u.imm = zero_ext(f);
         end else begin
            u.imm = '0;
         end
         u.prog = req.prog;
         u.last = (k == n);
         exp_q.push_back(u);
      end
   endtask

   task automatic note_error();
      error_count++;
      cur_err++;
   endtask

   task automatic check_bit(input string name, input logic exp, input logic got);
      if (got !== exp) begin
         $display("FAIL time %0t: %s expected %b, got %b", $time, name, exp, got);
         note_error();
      end
   endtask

   always @(posedge clk) begin
      if (!rst_n) begin
         busy_m     = 1'b0;
         full_m     = 1'b0;
         left_m     = 0;
         prev_stall = 1'b0;
         exp_q.delete();
      end else begin
         // Handshake levels against the cycle model
         check_bit("dec_ready", !busy_m, dec_ready);
         check_bit("uop_valid", full_m, uop_valid);
         exp_int = full_m && uop_ready && (exp_q.size() > 0) && exp_q[0].last &&
                   (exp_q[0].prog == PROG_INT);
         check_bit("int_done", exp_int, int_done);
         if (prev_stall && (uop !== prev_uop)) begin
            $display("FAIL time %0t: uop changed while stalled", $time);
            note_error();
         end

         if (uop_valid && uop_ready) begin
            if (exp_q.size() == 0) begin
               $display("A micro-operation was accepted with no request outstanding at %0t",
                        $time);
               note_error();
            end else begin
               exp_uop = exp_q.pop_front();
               uops_checked++;
               if (uop !== exp_uop) begin
                  $display("FAIL time %0t: test %0d step %0d uop expected %h, got %h",
                           $time, tests_done, step_idx, exp_uop, uop);
                  note_error();
               end
               step_idx++;
               if (exp_uop.last) begin
                  $display("test %0d prog %0d: %s, %0d uops", tests_done, exp_uop.prog,
                           (cur_err == 0) ? "PASS" : "FAIL", step_idx);
                  if (cur_err == 0) begin
                     tests_passed++;
                  end else begin
                     tests_failed++;
                  end
                  tests_done++;
                  cur_err  = 0;
                  step_idx = 0;
               end
            end
         end

         accept = dec_valid && dec_ready;
         if (accept) begin
            if (!reset_reported) begin
               $display("test reset: %s", (cur_err == 0) ? "PASS" : "FAIL");
               if (cur_err == 0) begin
                  tests_passed++;
               end else begin
                  tests_failed++;
               end
               cur_err        = 0;
               reset_reported = 1'b1;
            end
            expand_request(dec_req, eip, eflags);
         end

         // Stage model: one register behind a step counter
         take_m = busy_m && (!full_m || uop_ready);
         full_m = take_m || (full_m && !uop_ready);
         if (take_m) begin
            left_m--;
            if (left_m == 0) begin
               busy_m = 1'b0;
            end
         end
         if (accept) begin
            busy_m = 1'b1;
            left_m = PROG_LAST[dec_req.prog] + 1;
         end

         prev_stall = uop_valid && !uop_ready;
         prev_uop   = uop;
      end
   end

   always @(posedge run_end) begin
      $display("Tests passed %0d, failed %0d, micro-operations checked %0d, errors %0d",
               tests_passed, tests_failed, uops_checked, error_count);
   end

endmodule

`default_nettype wire

// ==== tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
   parameter int PERIOD       = 100,
   parameter int RESET_CYCLES = 8
) (
   output logic clk,
   output logic rst_n
);

   initial begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   // Reset released on a rising edge after the hold cycles
   initial begin
      rst_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      rst_n <= 1'b1;
   end

endmodule

`default_nettype wire

// ==== ucode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module ucode_stage #(
   parameter int EIP_W = 32
) (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    dec_valid,
   output logic                    dec_ready,
   input  ucode_pkg::dec_req_t     dec_req,
   input  logic [EIP_W-1:0]        eip,
   input  logic [EIP_W-1:0]        eflags,
   output ucode_pkg::uop_t         uop,
   output logic                    uop_valid,
   input  logic                    uop_ready,
   output logic                    int_done
);
   import ucode_pkg::*;

   ucode_prog_e         prog;
   logic [UCODE_AW-1:0] count;
   logic [UCODE_AW-1:0] prog_last;
   logic [IMM_W-1:0]    dec_imm;
   rom_word_t           word;
   logic                issue;
   logic                last;
   logic                take;

   ucode_seq_ctrl ucode_seq_ctrl_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .dec_valid (dec_valid),
      .dec_ready (dec_ready),
      .dec_req   (dec_req),
      .prog_last (prog_last),
      .take      (take),
      .prog      (prog),
      .count     (count),
      .dec_imm   (dec_imm),
      .issue     (issue),
      .last      (last)
   );

   ucode_rom ucode_rom_inst (
      .prog      (prog),
      .count     (count),
      .prog_last (prog_last),
      .word      (word)
   );

   ucode_uop_build #(
      .EIP_W (EIP_W)
   ) ucode_uop_build_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .issue     (issue),
      .last      (last),
      .prog      (prog),
      .dec_imm   (dec_imm),
      .word      (word),
      .eip       (eip),
      .eflags    (eflags),
      .take      (take),
      .uop       (uop),
      .uop_valid (uop_valid),
      .uop_ready (uop_ready),
      .int_done  (int_done)
   );

endmodule

`default_nettype wire

// ==== ucode_uop_build.sv ====
`timescale 1ns/1ps
`default_nettype none

module ucode_uop_build #(
   parameter int EIP_W = 32
) (
   input  logic                          clk,
   input  logic                          rst_n,
   input  logic                          issue,
   input  logic                          last,
   input  ucode_pkg::ucode_prog_e        prog,
   input  logic [ucode_pkg::IMM_W-1:0]   dec_imm,
   input  ucode_pkg::rom_word_t          word,
   input  logic [EIP_W-1:0]              eip,
   input  logic [EIP_W-1:0]              eflags,
   output logic                          take,
   output ucode_pkg::uop_t               uop,
   output logic                          uop_valid,
   input  logic                          uop_ready,
   output logic                          int_done
);
   import ucode_pkg::*;

   logic [IMM_W-1:0] imm;
   uop_t             uop_d;

   // Register free, or draining this cycle
   assign take = issue && (!uop_valid || uop_ready);

   // Immediate source select
   always_comb begin
      case (word.imm_sel)
         IMM_DEC:    imm = dec_imm;
         IMM_EIP:    imm = IMM_W'(eip);
         IMM_EFLAGS: imm = IMM_W'(eflags);
         default:    imm = '0;
      endcase
   end

   always_comb begin
      uop_d.size               = word.size;
      uop_d.set_d              = word.set_d;
      uop_d.clr_d              = word.clr_d;
      uop_d.op0                = word.op0;
      uop_d.op1                = word.op1;
      uop_d.op0_reg            = word.op0_reg;
      uop_d.op1_reg            = word.op1_reg;
      uop_d.modrm              = word.modrm;
      uop_d.sib                = word.sib;
      uop_d.alu_op             = word.alu_op;
      uop_d.flag0              = word.flag0;
      uop_d.flag1              = word.flag1;
      uop_d.stack_op           = word.stack_op;
      uop_d.seg_override       = word.seg_override;
      uop_d.seg_override_valid = word.seg_override_valid;
      uop_d.imm                = imm;
      uop_d.prog               = prog;
      uop_d.last               = last;
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         uop_valid <= 1'b0;
      end else if (take) begin
         uop_valid <= 1'b1;
      end else if (uop_ready) begin
         uop_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (take) begin
         uop <= uop_d;
      end
   end

   // Last step of interrupt entry leaving the stage
   assign int_done = uop_valid && uop_ready && uop.last && (uop.prog == PROG_INT);

   a_uop_stable : assert property (
      @(posedge clk) disable iff (!rst_n)
      (uop_valid && !uop_ready) |=> (uop_valid && $stable(uop))
   );

endmodule

`default_nettype wire

// ==== ucode_rom.sv ====
`timescale 1ns/1ps
`default_nettype none

module ucode_rom (
   input  ucode_pkg::ucode_prog_e           prog,
   input  logic [ucode_pkg::UCODE_AW-1:0]   count,
   output logic [ucode_pkg::UCODE_AW-1:0]   prog_last,
   output ucode_pkg::rom_word_t             word
);
   import ucode_pkg::*;

   `include "ucode_image.svh"

   logic [UCODE_AW-1:0] offset;
   // One extra bit to catch a program running off the end of the ROM
   logic [UCODE_AW:0]   addr_full;
   logic [UCODE_AW-1:0] addr;

   // Program table lookup
   always_comb begin
      offset    = PROG_OFFSET[prog];
      prog_last = PROG_LAST[prog];
   end

   // Address generation
   assign addr_full = {1'b0, offset} + {1'b0, count};
   assign addr      = addr_full[UCODE_AW-1:0];

   // ROM read
   always_comb begin
      word = UCODE_IMAGE[addr];
   end

   always_comb begin
      a_addr_in_rom : assert final (addr_full < UCODE_DEPTH);
   end

endmodule

`default_nettype wire

// ==== ucode_seq_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module ucode_seq_ctrl (
   input  logic                             clk,
   input  logic                             rst_n,
   input  logic                             dec_valid,
   output logic                             dec_ready,
   input  ucode_pkg::dec_req_t              dec_req,
   input  logic [ucode_pkg::UCODE_AW-1:0]   prog_last,
   input  logic                             take,
   output ucode_pkg::ucode_prog_e           prog,
   output logic [ucode_pkg::UCODE_AW-1:0]   count,
   output logic [ucode_pkg::IMM_W-1:0]      dec_imm,
   output logic                             issue,
   output logic                             last
);
   import ucode_pkg::*;

   typedef enum logic {
      ST_IDLE = 1'b0,
      ST_BUSY = 1'b1
   } state_e;

   state_e              state_q;
   state_e              state_d;
   ucode_prog_e         prog_q;
   logic [IMM_W-1:0]    imm_q;
   logic [UCODE_AW-1:0] count_q;
   logic                accept;

   assign dec_ready = (state_q == ST_IDLE);
   assign accept    = dec_valid && dec_ready;
   assign issue     = (state_q == ST_BUSY);
   assign last      = (count_q == prog_last);

   assign prog    = prog_q;
   assign dec_imm = imm_q;
   assign count   = count_q;

   always_comb begin
      state_d = state_q;
      case (state_q)
         ST_IDLE: begin
            if (accept) begin
               state_d = ST_BUSY;
            end
         end
         ST_BUSY: begin
            // Final step handed to the output register
            if (take && last) begin
               state_d = ST_IDLE;
            end
         end
         default: state_d = ST_IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state_q <= ST_IDLE;
         prog_q  <= PROG_0;
         count_q <= '0;
      end else begin
         state_q <= state_d;
         if (accept) begin
            prog_q <= dec_req.prog;
         end
         // Count wraps to zero after the last step, ready for the next request
         if (take) begin
            count_q <= last ? '0 : count_q + 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         imm_q <= dec_req.dec_imm;
      end
   end

   // Every program starts from its first word
   a_start_at_zero : assert property (
      @(posedge clk) disable iff (!rst_n) accept |=> (issue && (count_q == '0))
   );

   // Step counter stays inside the selected program
   a_count_in_prog : assert property (
      @(posedge clk) disable iff (!rst_n) issue |-> (count_q <= prog_last)
   );

endmodule

`default_nettype wire

// ==== ucode_pkg.sv ====
`default_nettype none

package ucode_pkg;

   localparam int UCODE_DEPTH = 32;
   localparam int UCODE_AW    = 5;
   localparam int IMM_W       = 48;

   // Microprogram number handed over by the decoder
   typedef enum logic [2:0] {
      PROG_0   = 3'd0,
      PROG_1   = 3'd1,
      PROG_2   = 3'd2,
      PROG_3   = 3'd3,
      PROG_4   = 3'd4,
      PROG_5   = 3'd5,
      PROG_INT = 3'd6,
      PROG_7   = 3'd7
   } ucode_prog_e;

   typedef enum logic [1:0] {
      IMM_DEC    = 2'd0,
      IMM_EIP    = 2'd1,
      IMM_EFLAGS = 2'd2,
      IMM_ZERO   = 2'd3
   } imm_sel_e;

   typedef enum logic [3:0] {
      ALU_PASS = 4'd0,
      ALU_ADD  = 4'd1,
      ALU_SUB  = 4'd2,
      ALU_AND  = 4'd3,
      ALU_OR   = 4'd4,
      ALU_XOR  = 4'd5,
      ALU_INC  = 4'd6,
      ALU_DEC  = 4'd7
   } alu_op_e;

   typedef enum logic [1:0] {
      STK_NONE = 2'd0,
      STK_PUSH = 2'd1,
      STK_POP  = 2'd2
   } stack_op_e;

   // One microcode word, MSB first
   typedef struct packed {
      logic [2:0] size;
      logic       set_d;
      logic       clr_d;
      logic [2:0] op0;
      logic [2:0] op1;
      logic [2:0] op0_reg;
      logic [2:0] op1_reg;
      logic [7:0] modrm;
      logic [7:0] sib;
      alu_op_e    alu_op;
      logic [2:0] flag0;
      logic [2:0] flag1;
      stack_op_e  stack_op;
      logic [2:0] seg_override;
      logic       seg_override_valid;
      imm_sel_e   imm_sel;
   } rom_word_t;

   typedef struct packed {
      ucode_prog_e      prog;
      logic [IMM_W-1:0] dec_imm;
   } dec_req_t;

   typedef struct packed {
      logic [2:0]       size;
      logic             set_d;
      logic             clr_d;
      logic [2:0]       op0;
      logic [2:0]       op1;
      logic [2:0]       op0_reg;
      logic [2:0]       op1_reg;
      logic [7:0]       modrm;
      logic [7:0]       sib;
      alu_op_e          alu_op;
      logic [2:0]       flag0;
      logic [2:0]       flag1;
      stack_op_e        stack_op;
      logic [2:0]       seg_override;
      logic             seg_override_valid;
      logic [IMM_W-1:0] imm;
      ucode_prog_e      prog;
      logic             last;
   } uop_t;

endpackage

`default_nettype wire

// ==== ucode_image.svh ====
// Field order per word:
// size set_d clr_d op0 op1 op0_reg op1_reg modrm sib alu flag0 flag1 stack seg seg_v imm_sel
// imm_sel 0 dec, 1 eip, 2 eflags, 3 zero; stack 0 none, 1 push, 2 pop

localparam ucode_pkg::rom_word_t UCODE_IMAGE [ucode_pkg::UCODE_DEPTH] = '{
   // Program 0
    0: {3'd2,1'b0,1'b0,3'd1,3'd4,3'd0,3'd0,8'hc0,8'h00,4'd1,3'd1,3'd0,2'd0,3'd0,1'b0,2'd0},
    1: {3'd2,1'b0,1'b0,3'd2,3'd1,3'd0,3'd1,8'h04,8'h24,4'd0,3'd0,3'd0,2'd0,3'd3,1'b1,2'd3},
    2: {3'd2,1'b0,1'b0,3'd1,3'd1,3'd0,3'd1,8'hc1,8'h00,4'd2,3'd1,3'd2,2'd0,3'd0,1'b0,2'd3},
    3: {3'd2,1'b0,1'b0,3'd3,3'd1,3'd0,3'd0,8'h05,8'h00,4'd0,3'd0,3'd0,2'd0,3'd2,1'b1,2'd0},
   // Interrupt entry, shared head of programs 3 to 7
    4: {3'd2,1'b0,1'b0,3'd4,3'd0,3'd4,3'd0,8'h00,8'h00,4'd0,3'd0,3'd0,2'd1,3'd2,1'b1,2'd2},
    5: {3'd1,1'b0,1'b0,3'd5,3'd0,3'd4,3'd1,8'h00,8'h00,4'd0,3'd0,3'd0,2'd1,3'd2,1'b1,2'd3},
    6: {3'd2,1'b0,1'b1,3'd4,3'd0,3'd4,3'd0,8'h00,8'h00,4'd0,3'd0,3'd0,2'd1,3'd2,1'b1,2'd1},
   // Program 1 body, program 2 starts at 7
    7: {3'd2,1'b0,1'b0,3'd6,3'd3,3'd0,3'd0,8'h00,8'h00,4'd0,3'd0,3'd0,2'd0,3'd0,1'b0,2'd0},
    8: {3'd2,1'b1,1'b0,3'd1,3'd3,3'd0,3'd0,8'hc0,8'h00,4'd4,3'd1,3'd0,2'd0,3'd0,1'b0,2'd0},
    9: {3'd2,1'b0,1'b0,3'd1,3'd0,3'd5,3'd0,8'h00,8'h00,4'd0,3'd0,3'd0,2'd2,3'd2,1'b1,2'd3},
   10: {3'd2,1'b0,1'b0,3'd1,3'd1,3'd3,3'd3,8'hdb,8'h00,4'd5,3'd1,3'd3,2'd0,3'd0,1'b0,2'd3},
   11: {3'd0,1'b0,1'b0,3'd2,3'd3,3'd0,3'd0,8'h44,8'h8d,4'd6,3'd2,3'd0,2'd0,3'd1,1'b1,2'd0},
   // Unused words decode as plain pass with a decoder immediate
   default: '0
};

// Start address per program, indexed by program number
localparam logic [ucode_pkg::UCODE_AW-1:0] PROG_OFFSET [0:7] = '{
   5'd0, 5'd6, 5'd7, 5'd4, 5'd4, 5'd4, 5'd4, 5'd4
};

// Program length minus one
localparam logic [ucode_pkg::UCODE_AW-1:0] PROG_LAST [0:7] = '{
   5'd3, 5'd5, 5'd2, 5'd4, 5'd4, 5'd2, 5'd2, 5'd4
};
